/* hdl/na_defines.svh */
`ifndef NA_DEFINES_SVH
`define NA_DEFINES_SVH

////////////////////////////////////////////////////////////
// NoC side
////////////////////////////////////////////////////////////

// Width of one flit on the network channel
`define NA_FLIT_WIDTH 32

// Entries per flit FIFO, a power of two (2, 4 or 8)
`define NA_FIFO_DEPTH 4

// Identity of this tile, matched against the header destination
`define NA_TILE_ID 5'd3

////////////////////////////////////////////////////////////
// Bus side
////////////////////////////////////////////////////////////

`define NA_APB_AW 12

`endif

/* hdl/na_noc_pkg.sv */
`include "na_defines.svh"

package na_noc_pkg;

  ////////////////////////////////////////////////////////////
  // Flit word
  ////////////////////////////////////////////////////////////

  // One flit as carried on the channel
  typedef logic [`NA_FLIT_WIDTH-1:0] flit_t;

  ////////////////////////////////////////////////////////////
  // Flit views
  ////////////////////////////////////////////////////////////

  // First flit of a packet is a header, the rest are payload.
  // The same word is read either way, depending on position.
  typedef union packed {
    // Header view
    struct packed {
      // Destination tile
      logic [4:0]  dest;
      // Message class
      logic [2:0]  cls;
      // Sending tile
      logic [4:0]  src;
      // Free for software
      logic [18:0] payload;
    } hdr;
    // Whole data word
    flit_t raw;
  } flit_u;

endpackage

/* hdl/na_bus_pkg.sv */
package na_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  // Region selected by address bits 11 to 8, others unmapped
  typedef enum logic [3:0] {
    REGION_CONF = 4'd0,
    REGION_MP   = 4'd1
  } region_e;

  // Configuration block, byte offsets
  typedef enum logic [7:0] {
    TILE_ID    = 8'h00,
    IRQ_EN     = 8'h04,
    DROP_COUNT = 8'h08
  } conf_reg_e;

  // Message-passing endpoint, byte offsets
  typedef enum logic [7:0] {
    // Push, last clear
    SEND      = 8'h00,
    // Push, last set
    SEND_LAST = 8'h04,
    // Pop head of receive FIFO
    RECV      = 8'h08,
    STATUS    = 8'h0C
  } mp_reg_e;

endpackage

/* hdl/na_flit_fifo.sv */
`include "na_defines.svh"

module na_flit_fifo (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 push_i,
  input  na_noc_pkg::flit_t                    push_flit_i,
  input  logic                                 push_last_i,
  input  logic                                 pop_i,
  output na_noc_pkg::flit_t                    head_flit_o,
  output logic                                 head_last_o,
  output logic [$clog2(`NA_FIFO_DEPTH+1)-1:0]  count_o,
  output logic                                 full_o,
  output logic                                 empty_o
);
  import na_noc_pkg::*;

  localparam int unsigned DEPTH = `NA_FIFO_DEPTH;
  localparam int unsigned PW    = $clog2(DEPTH);

  flit_t         mem_flit [DEPTH];
  logic          mem_last [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  // Overflow and underflow requests are dropped here
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (count_o == DEPTH);
  assign empty_o = (count_o == '0);

  assign head_flit_o = mem_flit[rd_ptr];
  assign head_last_o = mem_last[rd_ptr];

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_flit[wr_ptr] <= push_flit_i;
      mem_last[wr_ptr] <= push_last_i;
    end
  end

endmodule

/* hdl/na_conf.sv */
`include "na_defines.svh"

module na_conf (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        sel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        ready_o,
  output logic        err_o,
  input  logic        drop_i,
  output logic        irq_en_o
);
  import na_bus_pkg::*;

  conf_reg_e  offset;
  logic       wr_access;
  logic       irq_en;
  logic [7:0] drop_count;

  assign offset    = conf_reg_e'(addr_i);
  assign wr_access = sel_i && penable_i && pwrite_i;

  // No wait states in this block
  assign ready_o = sel_i;
  assign err_o   = sel_i && pwrite_i && !(offset inside {TILE_ID, IRQ_EN, DROP_COUNT});

  assign irq_en_o = irq_en;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_en     <= 1'b0;
      drop_count <= '0;
    end else begin
      if (wr_access && offset == IRQ_EN) irq_en <= wdata_i[0];
      // A clear keeps a drop arriving in the same cycle
      if (wr_access && offset == DROP_COUNT) begin
        drop_count <= {7'd0, drop_i};
      end else if (drop_i && drop_count != 8'hff) begin
        drop_count <= drop_count + 8'd1;
      end
    end
  end

  // Read mux
  always_comb begin
    case (offset)
      TILE_ID:    rdata_o = {27'd0, `NA_TILE_ID};
      IRQ_EN:     rdata_o = {31'd0, irq_en};
      DROP_COUNT: rdata_o = {24'd0, drop_count};
      default:    rdata_o = '0;
    endcase
  end

endmodule

/* hdl/na_mp_endpoint.sv */
`include "na_defines.svh"

module na_mp_endpoint (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              sel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [7:0]        addr_i,
  input  logic [31:0]       wdata_i,
  output logic [31:0]       rdata_o,
  output logic              ready_o,
  output logic              err_o,
  input  logic              irq_en_i,
  output logic              irq_o,
  output logic              drop_o,
  input  na_noc_pkg::flit_t noc_in_flit_i,
  input  logic              noc_in_last_i,
  input  logic              noc_in_valid_i,
  output logic              noc_in_ready_o,
  output na_noc_pkg::flit_t noc_out_flit_o,
  output logic              noc_out_last_o,
  output logic              noc_out_valid_o,
  input  logic              noc_out_ready_i
);
  import na_noc_pkg::*;
  import na_bus_pkg::*;

  localparam int unsigned CNT_W = $clog2(`NA_FIFO_DEPTH + 1);

  mp_reg_e    offset;
  logic       access;
  logic       send_off;
  logic       tx_push;
  logic       tx_pop;
  logic       tx_full;
  logic       tx_empty;
  logic [CNT_W-1:0] tx_count;
  logic [CNT_W-1:0] rx_count;
  logic       rx_push;
  logic       rx_pop;
  logic       rx_full;
  logic       rx_empty;
  flit_t      rx_head_flit;
  logic       rx_head_last;
  logic [3:0] rx_cnt4;
  logic [3:0] tx_free4;
  logic [31:0] status_word;
  flit_u      in_word;
  logic       in_xfer;
  logic       in_pkt;
  logic       dropping;
  logic       misrouted;
  logic       irq_q;

  assign offset   = mp_reg_e'(addr_i);
  assign access   = sel_i && penable_i;
  assign send_off = (offset == SEND) || (offset == SEND_LAST);

  ////////////////////////////////////////////////////////////
  // Send path
  ////////////////////////////////////////////////////////////

  // Stall the bus while the transmit FIFO has no room
  assign ready_o = sel_i && !(pwrite_i && send_off && tx_full);
  assign tx_push = access && pwrite_i && send_off && !tx_full;
  assign tx_pop  = noc_out_valid_o && noc_out_ready_i;

  assign noc_out_valid_o = !tx_empty;

  na_flit_fifo tx_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (tx_push),
    .push_flit_i (wdata_i),
    .push_last_i (offset == SEND_LAST),
    .pop_i       (tx_pop),
    .head_flit_o (noc_out_flit_o),
    .head_last_o (noc_out_last_o),
    .count_o     (tx_count),
    .full_o      (tx_full),
    .empty_o     (tx_empty)
  );

  ////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////

  assign in_word = noc_in_flit_i;
  assign in_xfer = noc_in_valid_i && noc_in_ready_o;

  // Header flit for another tile
  assign misrouted = !in_pkt && (in_word.hdr.dest != `NA_TILE_ID);

  assign noc_in_ready_o = dropping || !rx_full;
  assign rx_push        = in_xfer && !dropping && !misrouted;
  assign drop_o         = in_xfer && noc_in_last_i && (dropping || misrouted);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_pkt   <= 1'b0;
      dropping <= 1'b0;
    end else if (in_xfer) begin
      in_pkt <= !noc_in_last_i;
      if (noc_in_last_i) begin
        dropping <= 1'b0;
      end else if (misrouted) begin
        dropping <= 1'b1;
      end
    end
  end

  na_flit_fifo rx_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (rx_push),
    .push_flit_i (in_word.raw),
    .push_last_i (noc_in_last_i),
    .pop_i       (rx_pop),
    .head_flit_o (rx_head_flit),
    .head_last_o (rx_head_last),
    .count_o     (rx_count),
    .full_o      (rx_full),
    .empty_o     (rx_empty)
  );

  ////////////////////////////////////////////////////////////
  // Register reads
  ////////////////////////////////////////////////////////////

  assign rx_pop = access && !pwrite_i && (offset == RECV) && !rx_empty;

  // Reading an empty FIFO or writing a read-only offset is an error
  assign err_o = sel_i && ((!pwrite_i && offset == RECV && rx_empty) ||
                           (pwrite_i && !send_off));

  assign rx_cnt4     = 4'(rx_count);
  assign tx_free4    = 4'(`NA_FIFO_DEPTH) - 4'(tx_count);
  assign status_word = {12'd0, tx_free4, 7'd0, rx_head_last && !rx_empty, 4'd0, rx_cnt4};

  always_comb begin
    case (offset)
      RECV:    rdata_o = rx_head_flit;
      STATUS:  rdata_o = status_word;
      default: rdata_o = '0;
    endcase
  end

  // Interrupt while enabled and data waits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= irq_en_i && !rx_empty;
    end
  end

  assign irq_o = irq_q;

endmodule

/* hdl/na_apb_decode.sv */
`include "na_defines.svh"

module na_apb_decode (
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`NA_APB_AW-1:0] paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic                  conf_sel_o,
  output logic                  mp_sel_o,
  output logic                  penable_o,
  output logic                  pwrite_o,
  output logic [7:0]            addr_o,
  output logic [31:0]           wdata_o,
  input  logic [31:0]           conf_rdata_i,
  input  logic                  conf_ready_i,
  input  logic                  conf_err_i,
  input  logic [31:0]           mp_rdata_i,
  input  logic                  mp_ready_i,
  input  logic                  mp_err_i
);
  import na_bus_pkg::*;

  region_e region;
  logic    slv_err;

  assign region = region_e'(paddr_i[`NA_APB_AW-1:8]);

  // Shared request lines
  assign penable_o = penable_i;
  assign pwrite_o  = pwrite_i;
  assign addr_o    = paddr_i[7:0];
  assign wdata_o   = pwdata_i;

  ////////////////////////////////////////////////////////////
  // Select and response merge
  ////////////////////////////////////////////////////////////

  always_comb begin
    conf_sel_o = 1'b0;
    mp_sel_o   = 1'b0;
    case (region)
      REGION_CONF: begin
        conf_sel_o = psel_i;
        prdata_o   = conf_rdata_i;
        pready_o   = conf_ready_i;
        slv_err    = conf_err_i;
      end
      REGION_MP: begin
        mp_sel_o = psel_i;
        prdata_o = mp_rdata_i;
        pready_o = mp_ready_i;
        slv_err  = mp_err_i;
      end
      // Unmapped, answered here at once
      default: begin
        prdata_o = '0;
        pready_o = psel_i;
        slv_err  = psel_i;
      end
    endcase
  end

  // Error only shows in the access phase
  assign pslverr_o = penable_i && slv_err;

endmodule

/* hdl/na_top.sv */
`include "na_defines.svh"

module na_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`NA_APB_AW-1:0] paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  na_noc_pkg::flit_t     noc_in_flit_i,
  input  logic                  noc_in_last_i,
  input  logic                  noc_in_valid_i,
  output logic                  noc_in_ready_o,
  output na_noc_pkg::flit_t     noc_out_flit_o,
  output logic                  noc_out_last_o,
  output logic                  noc_out_valid_o,
  input  logic                  noc_out_ready_i,
  output logic                  irq_o
);

  ////////////////////////////////////////////////////////////
  // Internal bus
  ////////////////////////////////////////////////////////////

  logic        conf_sel;
  logic        mp_sel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  addr;
  logic [31:0] wdata;
  logic [31:0] conf_rdata;
  logic        conf_ready;
  logic        conf_err;
  logic [31:0] mp_rdata;
  logic        mp_ready;
  logic        mp_err;

  // Between configuration and endpoint
  logic        drop;
  logic        irq_en;

  na_apb_decode u_decode (
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .conf_sel_o   (conf_sel),
    .mp_sel_o     (mp_sel),
    .penable_o    (penable),
    .pwrite_o     (pwrite),
    .addr_o       (addr),
    .wdata_o      (wdata),
    .conf_rdata_i (conf_rdata),
    .conf_ready_i (conf_ready),
    .conf_err_i   (conf_err),
    .mp_rdata_i   (mp_rdata),
    .mp_ready_i   (mp_ready),
    .mp_err_i     (mp_err)
  );

  na_conf u_conf (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .sel_i     (conf_sel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .addr_i    (addr),
    .wdata_i   (wdata),
    .rdata_o   (conf_rdata),
    .ready_o   (conf_ready),
    .err_o     (conf_err),
    .drop_i    (drop),
    .irq_en_o  (irq_en)
  );

  na_mp_endpoint u_mp (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .sel_i           (mp_sel),
    .penable_i       (penable),
    .pwrite_i        (pwrite),
    .addr_i          (addr),
    .wdata_i         (wdata),
    .rdata_o         (mp_rdata),
    .ready_o         (mp_ready),
    .err_o           (mp_err),
    .irq_en_i        (irq_en),
    .irq_o           (irq_o),
    .drop_o          (drop),
    .noc_in_flit_i   (noc_in_flit_i),
    .noc_in_last_i   (noc_in_last_i),
    .noc_in_valid_i  (noc_in_valid_i),
    .noc_in_ready_o  (noc_in_ready_o),
    .noc_out_flit_o  (noc_out_flit_o),
    .noc_out_last_o  (noc_out_last_o),
    .noc_out_valid_o (noc_out_valid_o),
    .noc_out_ready_i (noc_out_ready_i)
  );

endmodule

/* tb/na_properties.sv */
module na_properties (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              pready_i,
  input logic              pslverr_i,
  input na_noc_pkg::flit_t out_flit_i,
  input logic              out_last_i,
  input logic              out_valid_i,
  input logic              out_ready_i,
  input logic              irq_i
);
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////
  // NoC output channel
  ////////////////////////////////////////////////////////////

  // Stalled flit is held until accepted
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=>
      out_valid_i && $stable(out_flit_i) && $stable(out_last_i))
    else $error("noc_out flit or last changed while stalled");

  ////////////////////////////////////////////////////////////
  // APB response and reset state
  ////////////////////////////////////////////////////////////

  a_err_with_ready: assert property (@(posedge clk_i) pslverr_i |-> pready_i)
    else $error("pslverr high without pready");

  a_quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !out_valid_i && !irq_i)
    else $error("noc_out_valid or irq high right after reset");

endmodule

bind na_top na_properties u_properties (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .pready_i    (pready_o),
  .pslverr_i   (pslverr_o),
  .out_flit_i  (noc_out_flit_o),
  .out_last_i  (noc_out_last_o),
  .out_valid_i (noc_out_valid_o),
  .out_ready_i (noc_out_ready_i),
  .irq_i       (irq_o)
);

/* tb/na_tb.sv */
`include "na_defines.svh"

module na_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import na_noc_pkg::*;
  import na_bus_pkg::*;

  localparam int unsigned TIMEOUT     = 500;
  localparam int unsigned DEPTH       = `NA_FIFO_DEPTH;
  localparam logic [3:0]  CONF_REGION = 4'h0;
  localparam logic [3:0]  MP_REGION   = 4'h1;

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [`NA_APB_AW-1:0] paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  flit_t                 noc_in_flit;
  logic                  noc_in_last;
  logic                  noc_in_valid;
  logic                  noc_in_ready;
  flit_t                 noc_out_flit;
  logic                  noc_out_last;
  logic                  noc_out_valid;
  logic                  noc_out_ready;
  logic                  irq;

  // Reference model
  logic [31:0] rng_state;
  flit_t       tx_flits[$];
  logic        tx_lasts[$];
  flit_t       rx_flits[$];
  logic        rx_lasts[$];
  int unsigned drop_model;
  logic        irq_en_model;

  // Drain pattern for noc_out_ready that rotates every cycle
  logic [31:0] ready_pattern;
  logic [4:0]  ready_phase;
  logic        drain_enable;

  na_top i_na_top (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .psel_i          (psel),
    .penable_i       (penable),
    .pwrite_i        (pwrite),
    .paddr_i         (paddr),
    .pwdata_i        (pwdata),
    .prdata_o        (prdata),
    .pready_o        (pready),
    .pslverr_o       (pslverr),
    .noc_in_flit_i   (noc_in_flit),
    .noc_in_last_i   (noc_in_last),
    .noc_in_valid_i  (noc_in_valid),
    .noc_in_ready_o  (noc_in_ready),
    .noc_out_flit_o  (noc_out_flit),
    .noc_out_last_o  (noc_out_last),
    .noc_out_valid_o (noc_out_valid),
    .noc_out_ready_i (noc_out_ready),
    .irq_o           (irq)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                  $time, what, got, expected));
    end
  endtask

  task automatic timeout_fail(input string what);
    stop_with_failure($sformatf("Timeout at %0t: %s", $time, what));
  endtask

  // Starts and ends 2 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int unsigned waited;
    waited  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited > TIMEOUT) timeout_fail("APB transfer never completed");
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check_value(err, exp_err, $sformatf("pslverr of write to %h", addr));
  endtask

  task automatic reg_read(input logic [11:0] addr, input logic exp_err,
                          output logic [31:0] rdata);
    logic err;
    apb_access(1'b0, addr, 32'd0, rdata, err);
    check_value(err, exp_err, $sformatf("pslverr of read from %h", addr));
  endtask

  task automatic send_flit(input flit_t flit, input logic last);
    logic [7:0] offset;
    offset = last ? SEND_LAST : SEND;
    tx_flits.push_back(flit);
    tx_lasts.push_back(last);
    reg_write({MP_REGION, offset}, flit, 1'b0);
  endtask

  task automatic recv_flit();
    logic [31:0] rdata;
    flit_t       exp_flit;
    exp_flit = rx_flits.pop_front();
    void'(rx_lasts.pop_front());
    reg_read({MP_REGION, RECV}, 1'b0, rdata);
    check_value(rdata, exp_flit, "RECV flit");
  endtask

  // STATUS has rx count in 3..0, head last in 8 and tx free in 19..16
  function automatic logic [31:0] status_expect();
    logic [31:0] word;
    word        = 32'd0;
    word[3:0]   = 4'(rx_flits.size());
    word[8]     = (rx_lasts.size() != 0) ? rx_lasts[0] : 1'b0;
    word[19:16] = 4'(DEPTH - tx_flits.size());
    return word;
  endfunction

  task automatic check_status();
    logic [31:0] rdata;
    reg_read({MP_REGION, STATUS}, 1'b0, rdata);
    check_value(rdata, status_expect(), "STATUS word");
  endtask

  task automatic check_irq();
    @(posedge clk);
    @(negedge clk);
    check_value(irq, irq_en_model && (rx_flits.size() != 0), "irq_o");
    @(posedge clk);
    #2;
  endtask

  task automatic inject_flit(input flit_t flit, input logic last);
    int unsigned waited;
    waited       = 0;
    noc_in_flit  = flit;
    noc_in_last  = last;
    noc_in_valid = 1'b1;
    @(negedge clk);
    while (!noc_in_ready) begin
      waited++;
      if (waited > TIMEOUT) timeout_fail("NoC input never accepted a flit");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    noc_in_valid = 1'b0;
  endtask

  task automatic inject_packet(input logic [4:0] dest, input int unsigned len);
    flit_t       flit;
    logic        last;
    int unsigned i;
    for (i = 0; i < len; i++) begin
      flit = next_random();
      // Header carries the destination in its top five bits
      if (i == 0) flit[31:27] = dest;
      last = (i == len - 1);
      if (dest == `NA_TILE_ID) begin
        rx_flits.push_back(flit);
        rx_lasts.push_back(last);
      end
      inject_flit(flit, last);
    end
    if (dest != `NA_TILE_ID && drop_model < 255) drop_model++;
  endtask

  ////////////////////////////////////////////////////////////
  // Output drain and monitor
  ////////////////////////////////////////////////////////////

  initial begin
    noc_out_ready = 1'b0;
    ready_phase   = '0;
    forever begin
      @(posedge clk);
      #2;
      ready_phase   = ready_phase + 5'd1;
      noc_out_ready = drain_enable && ready_pattern[ready_phase];
    end
  end

  always @(negedge clk) begin
    if (rst_n && noc_out_valid && noc_out_ready) begin
      if (tx_flits.size() == 0) begin
        stop_with_failure("A flit left the NoC output when none was expected");
      end
      check_value(noc_out_flit, tx_flits.pop_front(), "noc_out flit");
      check_value(noc_out_last, tx_lasts.pop_front(), "noc_out last");
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rdata;
    logic [31:0] value;
    logic [4:0]  dest;
    int unsigned len;
    int unsigned pkt;
    int unsigned i;
    int unsigned waited;
    clk           = 1'b0;
    rst_n         = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    noc_in_flit   = '0;
    noc_in_last   = 1'b0;
    noc_in_valid  = 1'b0;
    rng_state     = 32'h78c3_1514;
    drop_model    = 0;
    irq_en_model  = 1'b0;
    ready_pattern = '0;
    drain_enable  = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value(noc_out_valid, 1'b0, "noc_out_valid after reset");
    check_value(pslverr, 1'b0, "pslverr after reset");
    check_value(pready, 1'b0, "pready while idle");
    check_value(irq, 1'b0, "irq_o after reset");
    @(posedge clk);
    #2;

    // Identity and interrupt enable
    reg_read({CONF_REGION, TILE_ID}, 1'b0, rdata);
    check_value(rdata, 32'(`NA_TILE_ID), "TILE_ID");
    value = next_random();
    reg_write({CONF_REGION, IRQ_EN}, value, 1'b0);
    irq_en_model = value[0];
    reg_read({CONF_REGION, IRQ_EN}, 1'b0, rdata);
    check_value(rdata, {31'd0, value[0]}, "IRQ_EN readback");
    check_irq();

    // First flit of the send path appears the cycle after its write
    send_flit(next_random(), 1'b1);
    @(negedge clk);
    check_value(noc_out_valid, 1'b1, "noc_out_valid after SEND_LAST");
    @(posedge clk);
    #2;
    check_status();
    for (pkt = 0; pkt < 20; pkt++) begin
      ready_pattern = next_random() | 32'h1;
      drain_enable  = 1'b1;
      len = 1 + next_random() % 6;
      for (i = 0; i < len; i++) begin
        send_flit(next_random(), i == len - 1);
      end
      drain_enable = 1'b0;
      check_status();
    end
    ready_pattern = '1;
    drain_enable  = 1'b1;
    waited        = 0;
    while (tx_flits.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) timeout_fail("transmit FIFO never drained");
      @(posedge clk);
      #2;
    end
    drain_enable = 1'b0;
    check_status();

    // Receive path with interrupt tracking
    irq_en_model = 1'b1;
    reg_write({CONF_REGION, IRQ_EN}, 32'd1, 1'b0);
    check_irq();
    for (pkt = 0; pkt < 16; pkt++) begin
      len = 1 + next_random() % DEPTH;
      while (rx_flits.size() + len > DEPTH) begin
        check_status();
        recv_flit();
        check_irq();
      end
      inject_packet(`NA_TILE_ID, len);
      check_irq();
      // Input stays open only while the receive FIFO has room
      @(negedge clk);
      check_value(noc_in_ready, rx_flits.size() < DEPTH, "noc_in_ready");
      @(posedge clk);
      #2;
      check_status();
      if (next_random() % 4 == 0) begin
        irq_en_model = !irq_en_model;
        reg_write({CONF_REGION, IRQ_EN}, {31'd0, irq_en_model}, 1'b0);
        check_irq();
      end
    end
    while (rx_flits.size() != 0) begin
      check_status();
      recv_flit();
      check_irq();
    end
    check_status();

    // Misrouted packets are dropped and counted
    reg_read({CONF_REGION, DROP_COUNT}, 1'b0, rdata);
    check_value(rdata, drop_model, "DROP_COUNT before drops");
    for (pkt = 0; pkt < 10; pkt++) begin
      dest = 5'(next_random());
      if (dest == `NA_TILE_ID) dest = dest ^ 5'h10;
      inject_packet(dest, 1 + next_random() % 6);
      reg_read({CONF_REGION, DROP_COUNT}, 1'b0, rdata);
      check_value(rdata, drop_model, "DROP_COUNT");
      value = next_random();
      if (value[0]) begin
        inject_packet(`NA_TILE_ID, 1 + (value >> 8) % 3);
        while (rx_flits.size() != 0) recv_flit();
      end
    end
    reg_write({CONF_REGION, DROP_COUNT}, next_random(), 1'b0);
    drop_model = 0;
    reg_read({CONF_REGION, DROP_COUNT}, 1'b0, rdata);
    check_value(rdata, 32'd0, "DROP_COUNT after clear");

    // Error responses
    reg_read({MP_REGION, RECV}, 1'b1, rdata);
    check_status();
    for (pkt = 0; pkt < 4; pkt++) begin
      value = next_random();
      reg_read({4'(2 + value % 14), value[15:8]}, 1'b1, rdata);
      check_value(rdata, 32'd0, "read data of unmapped region");
      reg_write({4'(2 + value % 14), value[15:8]}, next_random(), 1'b1);
      value = next_random();
      reg_write({CONF_REGION, 8'h0c + 8'(value % 240)}, next_random(), 1'b1);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* files.f */
+incdir+hdl
hdl/na_noc_pkg.sv
hdl/na_bus_pkg.sv
hdl/na_flit_fifo.sv
hdl/na_conf.sv
hdl/na_mp_endpoint.sv
hdl/na_apb_decode.sv
hdl/na_top.sv
tb/na_properties.sv
tb/na_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= na_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/100ps
LOG       ?= sim.log
PASS_MSG  ?= RESULT: PASS

SOURCES := $(filter-out +incdir%,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when the file list or a source is newer than the binary
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
